//--- hydra_switch.f
verilog/switch_pkg.sv
verilog/sync_fifo.sv
verilog/port_wr_frontend.sv
verilog/page_buffer.sv
verilog/queue_manager.sv
verilog/port_rd_frontend.sv
verilog/hydra_switch.sv
bench/hydra_switch_checker.sv
bench/hydra_switch_assertions.sv
bench/hydra_switch_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = hydra_switch_tb
FILELIST  = hydra_switch.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- bench/hydra_switch_tb.sv
`timescale 1ns/1ns

module hydra_switch_tb;

    // Longest test runs a few thousand cycles
    localparam int timeout_cycles = 20000;
    localparam int drain_cycles = 2000;
    localparam int burst_len = 10;

    typedef int id_q_t [$];

    logic                                                clk;
    logic                                                rst_n;
    switch_pkg::beat_t [switch_pkg::num_ports-1:0]       in_beat;
    logic [switch_pkg::num_ports-1:0]                    full;
    switch_pkg::beat_t [switch_pkg::num_ports-1:0]       out_beat;
    logic [switch_pkg::num_ports-1:0]                    ready;

    integer seed = 32'hb33b4447;
    int     next_id = 0;
    int     cycles = 0;
    int     tb_errors = 0;
    int     tests = 0;
    bit     traffic_done;

    hydra_switch dut_i (
        .clk(clk), .rst_n(rst_n), .in_beat(in_beat), .full(full),
        .out_beat(out_beat), .ready(ready)
    );

    hydra_switch_checker chk_i (
        .clk(clk), .rst_n(rst_n), .out_beat(out_beat), .ready(ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Commit order in, output order out for one stalled output
    function automatic id_q_t expected_order(input id_q_t ids, input id_q_t prios);
        id_q_t res;
        if (ids.size() == 0) return res;
        // First packet is already staged in the read frontend
        res.push_back(ids[0]);
        for (int p = switch_pkg::num_prios - 1; p >= 0; p--) begin
            for (int k = 1; k < ids.size(); k++) begin
                if (prios[k] == p) res.push_back(ids[k]);
            end
        end
        return res;
    endfunction

    task automatic send_packet(input int src, input int dest, input int prio, input int len,
                               output int id);
        logic [127:0]      w;
        switch_pkg::beat_t b;
        id = next_id;
        next_id++;
        w = '0;
        for (int i = 0; i < len; i++) begin
            if (i == 0) w[15:0] = {id[9:0], src[1:0], prio[1:0], dest[1:0]};
            else w[i*16 +: 16] = 16'(rand_below(65536));
        end
        chk_i.expect_packet(id, src, dest, prio, len, w);
        while (full[src]) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < len; i++) begin
            b.sop  = (i == 0);
            b.eop  = (i == len - 1);
            b.vld  = 1'b1;
            b.data = w[i*16 +: 16];
            in_beat[src] = b;
            @(posedge clk);
            #1;
        end
        in_beat[src] = '0;
    endtask

    // Negative dest picks a random destination per packet
    task automatic send_burst(input int src, input int n, input int dest);
        int id;
        int d;
        for (int k = 0; k < n; k++) begin
            d = (dest < 0) ? rand_below(switch_pkg::num_ports) : dest;
            send_packet(src, d, rand_below(switch_pkg::num_prios), rand_below(8) + 1, id);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (chk_i.outstanding() != 0 && waited < drain_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        chk_i.report_lost();
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d (%s) finished, %0d errors so far", tests, name,
                 tb_errors + chk_i.errors);
    endtask

    initial begin
        int    id;
        int    base;
        int    total;
        id_q_t ids;
        id_q_t prios;
        id_q_t order;
        rst_n        = 1'b0;
        in_beat      = '0;
        ready        = '1;
        traffic_done = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        if (full != '0 || out_beat[0].vld || out_beat[1].vld || out_beat[2].vld
            || out_beat[3].vld) begin
            $display("FAIL %0t: full or vld high after reset", $time);
            tb_errors++;
        end
        for (int len = 1; len <= switch_pkg::page_words; len++) begin
            send_packet(len % 4, (len + 1) % 4, len % 4, len, id);
            wait_drain();
        end
        end_test("single packets");

        fork
            send_burst(0, 4, 2);
            send_burst(1, 4, 2);
            send_burst(2, 4, 2);
            send_burst(3, 4, 2);
        join
        wait_drain();
        end_test("all sources to one output");

        ready[1] = 1'b0;
        send_packet(3, 1, 0, 3, id);
        ids.push_back(id);
        prios.push_back(0);
        send_packet(3, 1, 0, 4, id);
        ids.push_back(id);
        prios.push_back(0);
        send_packet(3, 1, 3, 2, id);
        ids.push_back(id);
        prios.push_back(3);
        // Last packet is queued once its source frees up
        while (full[3]) begin
            @(posedge clk);
            #1;
        end
        base = chk_i.arrival_count();
        ready[1] = 1'b1;
        wait_drain();
        order = expected_order(ids, prios);
        for (int k = 0; k < order.size(); k++) begin
            if (chk_i.arrival(base + k) != order[k]) begin
                $display("FAIL %0t: priority order position %0d got packet %0d, expected %0d",
                         $time, k, chk_i.arrival(base + k), order[k]);
                tb_errors++;
            end
        end
        end_test("strict priority");

        fork
            begin
                fork
                    send_burst(0, burst_len, -1);
                    send_burst(1, burst_len, -1);
                    send_burst(2, burst_len, -1);
                    send_burst(3, burst_len, -1);
                join
                traffic_done = 1'b1;
            end
            begin
                while (!traffic_done) begin
                    ready = 4'(rand_below(16));
                    @(posedge clk);
                    #1;
                end
            end
        join
        ready = '1;
        wait_drain();
        end_test("random back-pressure");

        ready = '0;
        fork
            begin
                fork
                    send_burst(0, burst_len, -1);
                    send_burst(1, burst_len, -1);
                    send_burst(2, burst_len, -1);
                    send_burst(3, burst_len, -1);
                join
            end
            begin
                repeat (600) @(posedge clk);
                #1;
                if (full == '0) begin
                    $display("FAIL %0t: no source held by full with the buffer exhausted", $time);
                    tb_errors++;
                end
                ready = '1;
            end
        join
        wait_drain();
        end_test("buffer exhaustion");

        total = tb_errors + chk_i.errors;
        $display("Summary: %0d tests, %0d packets checked, %0d errors", tests, chk_i.checks, total);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- bench/hydra_switch_assertions.sv
`timescale 1ns/1ns

module hydra_switch_assertions (
    input logic                                          clk,
    input logic                                          rst_n,
    input logic [switch_pkg::num_ports-1:0]              full,
    input switch_pkg::beat_t [switch_pkg::num_ports-1:0] out_beat,
    input logic [switch_pkg::num_ports-1:0]              ready
);

    logic [switch_pkg::num_ports-1:0] vld_bits;

    for (genvar i = 0; i < switch_pkg::num_ports; i++) begin : g_out
        assign vld_bits[i] = out_beat[i].vld;

        // Stalled beat holds still
        hold_a: assert property (@(posedge clk) disable iff (!rst_n)
            out_beat[i].vld && !ready[i] |=> $stable(out_beat[i]))
            else $error("Output %0d changed while stalled", i);

        sop_a: assert property (@(posedge clk) out_beat[i].sop |-> out_beat[i].vld)
            else $error("Output %0d shows sop without vld", i);
    end

    reset_a: assert property (@(posedge clk)
        rst_n && !$past(rst_n) |-> full == '0 && vld_bits == '0)
        else $error("full or vld active right after reset");

endmodule

bind hydra_switch hydra_switch_assertions assertions_i (
    .clk(clk), .rst_n(rst_n), .full(full), .out_beat(out_beat), .ready(ready)
);

//--- bench/hydra_switch_checker.sv
`timescale 1ns/1ns

module hydra_switch_checker (
    input logic                                          clk,
    input logic                                          rst_n,
    input switch_pkg::beat_t [switch_pkg::num_ports-1:0] out_beat,
    input logic [switch_pkg::num_ports-1:0]              ready
);

    logic [127:0] exp_words [1024];
    int           exp_len [1024];
    int           exp_src [1024];
    int           exp_dest [1024];
    int           exp_prio [1024];
    int           pending [$];
    int           arrivals [$];
    logic [127:0] rx_words [switch_pkg::num_ports];
    int           rx_cnt [switch_pkg::num_ports];
    int           errors = 0;
    int           checks = 0;

    task automatic expect_packet(input int id, input int src, input int dest, input int prio,
                                 input int len, input logic [127:0] w);
        exp_words[id] = w;
        exp_len[id]   = len;
        exp_src[id]   = src;
        exp_dest[id]  = dest;
        exp_prio[id]  = prio;
        pending.push_back(id);
    endtask

    function automatic int outstanding();
        return pending.size();
    endfunction

    function automatic int arrival_count();
        return arrivals.size();
    endfunction

    function automatic int arrival(input int k);
        return arrivals[k];
    endfunction

    task automatic report_lost();
        if (pending.size() != 0) begin
            $display("Lost packets: %0d sent packets never reached an output", pending.size());
            errors++;
            pending.delete();
        end
    endtask

    // Oldest pending packet of the same source, output and priority must match
    task automatic finish_packet(input int d);
        logic [15:0] hdr;
        int          id;
        int          src;
        int          prio;
        int          hit;
        hdr  = rx_words[d][15:0];
        id   = int'(hdr[15:6]);
        src  = int'(hdr[5:4]);
        prio = int'(hdr[3:2]);
        hit  = -1;
        for (int k = 0; k < pending.size(); k++) begin
            if (hit < 0 && exp_dest[pending[k]] == d && exp_prio[pending[k]] == prio
                && exp_src[pending[k]] == src) hit = k;
        end
        checks++;
        arrivals.push_back(id);
        if (hit < 0) begin
            $display("Unexpected packet with header %h arrived at output %0d", hdr, d);
            errors++;
        end else begin
            if (pending[hit] != id) begin
                $display("FAIL %0t: output %0d got packet %0d, expected packet %0d next",
                         $time, d, id, pending[hit]);
                errors++;
            end else if (rx_cnt[d] != exp_len[id] || rx_words[d] != exp_words[id]) begin
                $display("FAIL %0t: packet %0d at output %0d has wrong length or data",
                         $time, id, d);
                errors++;
            end
            pending.delete(hit);
        end
    endtask

    always @(posedge clk) begin
        for (int d = 0; d < switch_pkg::num_ports; d++) begin
            if (!rst_n) begin
                rx_cnt[d]   = 0;
                rx_words[d] = '0;
            end else if (out_beat[d].vld && ready[d]) begin
                if ((rx_cnt[d] == 0) != out_beat[d].sop) begin
                    $display("FAIL %0t: sop misplaced at output %0d", $time, d);
                    errors++;
                end
                if (rx_cnt[d] < switch_pkg::page_words) begin
                    rx_words[d][rx_cnt[d]*16 +: 16] = out_beat[d].data;
                end
                rx_cnt[d]++;
                if (out_beat[d].eop) begin
                    finish_packet(d);
                    rx_cnt[d]   = 0;
                    rx_words[d] = '0;
                end
            end
        end
    end

endmodule

//--- verilog/hydra_switch.sv
`timescale 1ns/1ns

module hydra_switch (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  switch_pkg::beat_t [switch_pkg::num_ports-1:0]  in_beat,
    output logic [switch_pkg::num_ports-1:0]               full,
    output switch_pkg::beat_t [switch_pkg::num_ports-1:0]  out_beat,
    input  logic [switch_pkg::num_ports-1:0]               ready
);

    logic [switch_pkg::num_ports-1:0]                      commit_req;
    logic [switch_pkg::num_ports-1:0]                      commit_gnt;
    switch_pkg::page_idx_t                                 alloc_page;
    switch_pkg::buf_wr_t [switch_pkg::num_ports-1:0]       buf_wr;
    logic [switch_pkg::num_ports-1:0]                      port_enq_vld;
    switch_pkg::pkt_desc_t [switch_pkg::num_ports-1:0]     port_enq_desc;
    logic                                                  enq_vld;
    switch_pkg::pkt_desc_t                                 enq_desc;
    logic [switch_pkg::num_ports-1:0]                      deq;
    switch_pkg::prio_t [switch_pkg::num_ports-1:0]         deq_prio;
    logic [switch_pkg::num_ports-1:0][switch_pkg::num_prios-1:0] nonempty;
    switch_pkg::pkt_desc_t [switch_pkg::num_ports-1:0][switch_pkg::num_prios-1:0] heads;
    logic [switch_pkg::num_ports-1:0]                      rd_req;
    switch_pkg::page_idx_t [switch_pkg::num_ports-1:0]     rd_page;
    switch_pkg::len_t [switch_pkg::num_ports-1:0]          rd_len;
    logic [switch_pkg::num_ports-1:0]                      rd_gnt;
    switch_pkg::data_t                                     rd_word;
    logic                                                  rd_word_vld;

    // At most one writer enqueues per cycle
    assign enq_vld = |port_enq_vld;
    always_comb begin
        enq_desc = port_enq_desc[0];
        for (int i = 1; i < switch_pkg::num_ports; i++) begin
            if (port_enq_vld[i]) enq_desc = port_enq_desc[i];
        end
    end

    for (genvar i = 0; i < switch_pkg::num_ports; i++) begin : g_port
        port_wr_frontend wr_i (
            .clk(clk), .rst_n(rst_n), .in_beat(in_beat[i]), .full(full[i]),
            .commit_req(commit_req[i]), .commit_gnt(commit_gnt[i]),
            .alloc_page(alloc_page), .buf_wr(buf_wr[i]),
            .enq_vld(port_enq_vld[i]), .enq_desc(port_enq_desc[i])
        );
        port_rd_frontend rd_i (
            .clk(clk), .rst_n(rst_n), .nonempty(nonempty[i]), .heads(heads[i]),
            .deq(deq[i]), .deq_prio(deq_prio[i]), .rd_req(rd_req[i]),
            .rd_page(rd_page[i]), .rd_len(rd_len[i]), .rd_gnt(rd_gnt[i]),
            .rd_word(rd_word), .rd_word_vld(rd_word_vld),
            .out_beat(out_beat[i]), .ready(ready[i])
        );
    end

    page_buffer buf_i (
        .clk(clk), .rst_n(rst_n), .commit_req(commit_req), .commit_gnt(commit_gnt),
        .alloc_page(alloc_page), .buf_wr(buf_wr), .rd_req(rd_req), .rd_page(rd_page),
        .rd_len(rd_len), .rd_gnt(rd_gnt), .rd_word(rd_word), .rd_word_vld(rd_word_vld)
    );

    queue_manager qm_i (
        .clk(clk), .rst_n(rst_n), .enq_vld(enq_vld), .enq_desc(enq_desc),
        .deq(deq), .deq_prio(deq_prio), .nonempty(nonempty), .heads(heads)
    );

endmodule

//--- verilog/port_rd_frontend.sv
`timescale 1ns/1ns

module port_rd_frontend (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [switch_pkg::num_prios-1:0]                  nonempty,
    input  switch_pkg::pkt_desc_t [switch_pkg::num_prios-1:0] heads,
    output logic                                              deq,
    output switch_pkg::prio_t                                 deq_prio,
    output logic                                              rd_req,
    output switch_pkg::page_idx_t                             rd_page,
    output switch_pkg::len_t                                  rd_len,
    input  logic                                              rd_gnt,
    input  switch_pkg::data_t                                 rd_word,
    input  logic                                              rd_word_vld,
    output switch_pkg::beat_t                                 out_beat,
    input  logic                                              ready
);

    typedef enum logic [1:0] {st_idle, st_req, st_fill, st_stream} state_t;

    state_t                           state;
    switch_pkg::pkt_desc_t            desc;
    switch_pkg::data_t                stage [switch_pkg::page_words];
    logic [switch_pkg::word_bits-1:0] idx;
    logic                             last_word;

    // Strict priority, highest set bit wins
    always_comb begin
        deq_prio = '0;
        for (int p = 0; p < switch_pkg::num_prios; p++) begin
            if (nonempty[p]) deq_prio = switch_pkg::prio_t'(p);
        end
    end

    assign deq       = (state == st_idle) && (|nonempty);
    assign rd_req    = (state == st_req);
    assign rd_page   = desc.page;
    assign rd_len    = desc.len;
    assign last_word = (switch_pkg::len_t'(idx) == desc.len - 1'b1);

    always_comb begin
        out_beat.vld  = (state == st_stream);
        out_beat.sop  = (state == st_stream) && (idx == '0);
        out_beat.eop  = (state == st_stream) && last_word;
        out_beat.data = stage[idx];
    end

    always_ff @(posedge clk) begin
        if (deq) desc <= heads[deq_prio];
        if (state == st_fill && rd_word_vld) stage[idx] <= rd_word;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: if (deq) state <= st_req;
                st_req: if (rd_gnt) begin
                    idx   <= '0;
                    state <= st_fill;
                end
                st_fill: if (rd_word_vld) begin
                    idx <= last_word ? '0 : idx + 1'b1;
                    if (last_word) state <= st_stream;
                end
                default: if (ready) begin
                    // Beat held until the sink takes it
                    idx <= idx + 1'b1;
                    if (last_word) state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/queue_manager.sv
`timescale 1ns/1ns

module queue_manager (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       enq_vld,
    input  switch_pkg::pkt_desc_t                      enq_desc,
    input  logic [switch_pkg::num_ports-1:0]           deq,
    input  switch_pkg::prio_t [switch_pkg::num_ports-1:0] deq_prio,
    output logic [switch_pkg::num_ports-1:0][switch_pkg::num_prios-1:0] nonempty,
    output switch_pkg::pkt_desc_t [switch_pkg::num_ports-1:0][switch_pkg::num_prios-1:0] heads
);

    // One queue per destination and priority
    for (genvar d = 0; d < switch_pkg::num_ports; d++) begin : g_dest
        for (genvar p = 0; p < switch_pkg::num_prios; p++) begin : g_prio
            logic push;
            logic pop;
            logic empty;

            assign push = enq_vld && (enq_desc.dest == switch_pkg::port_idx_t'(d))
                          && (enq_desc.prio == switch_pkg::prio_t'(p));
            assign pop  = deq[d] && (deq_prio[d] == switch_pkg::prio_t'(p));
            assign nonempty[d][p] = !empty;

            sync_fifo #(
                .payload_t (switch_pkg::pkt_desc_t),
                .depth     (switch_pkg::num_pages)
            ) desc_fifo_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .push      (push),
                .push_data (enq_desc),
                .pop       (pop),
                .head      (heads[d][p]),
                .empty     (empty)
            );
        end
    end

endmodule

//--- verilog/page_buffer.sv
`timescale 1ns/1ns

module page_buffer (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [switch_pkg::num_ports-1:0]                 commit_req,
    output logic [switch_pkg::num_ports-1:0]                 commit_gnt,
    output switch_pkg::page_idx_t                            alloc_page,
    input  switch_pkg::buf_wr_t [switch_pkg::num_ports-1:0]  buf_wr,
    input  logic [switch_pkg::num_ports-1:0]                 rd_req,
    input  switch_pkg::page_idx_t [switch_pkg::num_ports-1:0] rd_page,
    input  switch_pkg::len_t [switch_pkg::num_ports-1:0]     rd_len,
    output logic [switch_pkg::num_ports-1:0]                 rd_gnt,
    output switch_pkg::data_t                                rd_word,
    output logic                                             rd_word_vld
);

    switch_pkg::data_t mem [switch_pkg::num_pages][switch_pkg::page_words];

    switch_pkg::port_idx_t            commit_rr;
    switch_pkg::port_idx_t            commit_pick;
    switch_pkg::port_idx_t            wr_owner;
    switch_pkg::buf_wr_t              wr_sel;
    logic                             commit_ok;
    logic                             free_empty;
    switch_pkg::port_idx_t            rd_rr;
    switch_pkg::port_idx_t            rd_pick;
    logic                             rd_ok;
    logic                             rd_active;
    logic                             rd_last;
    switch_pkg::page_idx_t            rd_page_q;
    switch_pkg::len_t                 rd_len_q;
    logic [switch_pkg::word_bits-1:0] rd_cnt;

    // First requester at or after the pointer, wrapping
    function automatic switch_pkg::port_idx_t rr_pick(
        input logic [switch_pkg::num_ports-1:0] req,
        input switch_pkg::port_idx_t start
    );
        switch_pkg::port_idx_t idx;
        switch_pkg::port_idx_t pick;
        logic found;
        pick  = start;
        found = 1'b0;
        for (int i = 0; i < switch_pkg::num_ports; i++) begin
            idx = start + switch_pkg::port_idx_t'(i);
            if (!found && req[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    sync_fifo #(
        .payload_t (switch_pkg::page_idx_t),
        .depth     (switch_pkg::num_pages),
        .init_seq  (1'b1)
    ) free_list_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rd_last),
        .push_data (rd_page_q),
        .pop       (commit_ok),
        .head      (alloc_page),
        .empty     (free_empty)
    );

    // Only one writer at a time, so a busy writer blocks new grants
    assign wr_sel      = buf_wr[wr_owner];
    assign commit_pick = rr_pick(commit_req, commit_rr);
    assign commit_ok   = (|commit_req) && !free_empty && !wr_sel.we;

    assign rd_pick = rr_pick(rd_req, rd_rr);
    assign rd_ok   = (|rd_req) && !rd_active;
    assign rd_last = rd_active && (switch_pkg::len_t'(rd_cnt) == rd_len_q - 1'b1);

    always_comb begin
        commit_gnt = '0;
        rd_gnt     = '0;
        if (commit_ok) commit_gnt[commit_pick] = 1'b1;
        if (rd_ok) rd_gnt[rd_pick] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_sel.we) mem[wr_sel.page][wr_sel.offset] <= wr_sel.data;
        rd_word <= mem[rd_page_q][rd_cnt];
        if (rd_ok) begin
            rd_page_q <= rd_page[rd_pick];
            rd_len_q  <= rd_len[rd_pick];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_rr   <= '0;
            wr_owner    <= '0;
            rd_rr       <= '0;
            rd_active   <= 1'b0;
            rd_cnt      <= '0;
            rd_word_vld <= 1'b0;
        end else begin
            rd_word_vld <= rd_active;
            if (commit_ok) begin
                wr_owner  <= commit_pick;
                commit_rr <= commit_pick + 1'b1;
            end
            if (rd_ok) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
                rd_rr     <= rd_pick + 1'b1;
            end else if (rd_active) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_last) rd_active <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/port_wr_frontend.sv
`timescale 1ns/1ns

module port_wr_frontend (
    input  logic                  clk,
    input  logic                  rst_n,
    input  switch_pkg::beat_t     in_beat,
    output logic                  full,
    output logic                  commit_req,
    input  logic                  commit_gnt,
    input  switch_pkg::page_idx_t alloc_page,
    output switch_pkg::buf_wr_t   buf_wr,
    output logic                  enq_vld,
    output switch_pkg::pkt_desc_t enq_desc
);

    typedef enum logic [2:0] {st_idle, st_recv, st_req, st_copy, st_enq} state_t;

    state_t                           state;
    switch_pkg::data_t                stage [switch_pkg::page_words];
    switch_pkg::len_t                 cnt;
    switch_pkg::len_t                 len;
    logic [switch_pkg::word_bits-1:0] idx;
    switch_pkg::page_idx_t            page_q;
    switch_pkg::port_idx_t            dest;
    switch_pkg::prio_t                prio;
    logic                             take;

    assign take = in_beat.vld && ((state == st_idle && in_beat.sop) || state == st_recv);

    assign commit_req = (state == st_req);
    assign enq_vld    = (state == st_enq);

    always_comb begin
        buf_wr.we     = (state == st_copy);
        buf_wr.page   = page_q;
        buf_wr.offset = idx;
        buf_wr.data   = stage[idx];
        enq_desc.page = page_q;
        enq_desc.len  = len;
        enq_desc.prio = prio;
        enq_desc.dest = dest;
    end

    // Packet words and header fields
    always_ff @(posedge clk) begin
        if (take) begin
            stage[cnt[switch_pkg::word_bits-1:0]] <= in_beat.data;
        end
        if (state == st_idle && take) begin
            dest <= in_beat.data[switch_pkg::hdr_dest_lsb +: 2];
            prio <= in_beat.data[switch_pkg::hdr_prio_lsb +: 2];
        end
        if (take && in_beat.eop) len <= cnt + 1'b1;
        if (commit_gnt) page_q <= alloc_page;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            full  <= 1'b0;
            cnt   <= '0;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: if (take) begin
                    full  <= 1'b1;
                    cnt   <= 4'd1;
                    state <= in_beat.eop ? st_req : st_recv;
                end
                st_recv: if (take) begin
                    cnt <= cnt + 1'b1;
                    if (in_beat.eop) state <= st_req;
                end
                st_req: if (commit_gnt) begin
                    idx   <= '0;
                    state <= st_copy;
                end
                st_copy: begin
                    idx <= idx + 1'b1;
                    if (switch_pkg::len_t'(idx) == len - 1'b1) state <= st_enq;
                end
                default: begin
                    // Descriptor goes out this cycle
                    full  <= 1'b0;
                    cnt   <= '0;
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 4,
    parameter bit init_seq = 1'b0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty
);

    localparam int ptr_bits = $clog2(depth);

    payload_t            mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0]   count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    // Free list starts full, holding every index once
    always_ff @(posedge clk) begin
        if (!rst_n && init_seq) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= payload_t'(i);
            end
        end else if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= init_seq ? (ptr_bits + 1)'(depth) : '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ptr_bits + 1)'(push) - (ptr_bits + 1)'(pop);
        end
    end

endmodule

//--- verilog/switch_pkg.sv
package switch_pkg;

    localparam int num_ports  = 4;
    localparam int num_prios  = 4;
    localparam int page_words = 8;
    localparam int num_pages  = 32;
    localparam int word_bits  = $clog2(page_words);

    // Header field positions in the first packet word
    localparam int hdr_dest_lsb = 0;
    localparam int hdr_prio_lsb = 2;

    typedef logic [15:0] data_t;
    typedef logic [1:0]  port_idx_t;
    typedef logic [1:0]  prio_t;
    typedef logic [4:0]  page_idx_t;
    typedef logic [3:0]  len_t;

    typedef struct packed {
        logic  sop;
        logic  eop;
        logic  vld;
        data_t data;
    } beat_t;

    typedef struct packed {
        page_idx_t page;
        len_t      len;
        prio_t     prio;
        port_idx_t dest;
    } pkt_desc_t;

    typedef struct packed {
        logic                 we;
        page_idx_t            page;
        logic [word_bits-1:0] offset;
        data_t                data;
    } buf_wr_t;

endpackage
